//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_inst_fetch_unit
FLIST = flist.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	@status=0; \
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || status=1; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+source
source/fetch_pkg.sv
source/inst_fetch.sv
source/inst_mem_access.sv
source/inst_matching_bridge.sv
source/inst_fetch_unit.sv
test/inst_fetch_asserts.sv
test/tb_inst_fetch_unit.sv

//--- source/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// First fetch address after reset
`define FETCH_RESET_VECTOR 32'h0000_1000

// Byte distance between fetches
// One fetch returns a 64-bit instruction pair
`define FETCH_STEP 8

// Outstanding requests tracked by the matching bridge
// Must be a power of two, at least 2
`define FETCH_BRIDGE_DEPTH 4

`endif

//--- source/fetch_pkg.sv
`default_nettype none
`include "fetch_defs.svh"

package fetch_pkg;

	// Instruction address
	typedef logic [31:0] addr_t;

	// Fetched instruction pair
	typedef logic [63:0] inst_data_t;

	// Bridge index width, pointer carries one extra wrap bit
	localparam int BRIDGE_IDX_W = $clog2(`FETCH_BRIDGE_DEPTH);
	typedef logic [BRIDGE_IDX_W:0] bridge_ptr_t;

	// Memory access controller states
	typedef enum logic {MEM_IDLE, MEM_HOLD} mem_state_t;

endpackage

`default_nettype wire

//--- source/inst_fetch.sv
`timescale 1ns/1ns
`default_nettype none
`include "fetch_defs.svh"

module inst_fetch (
	input logic iclock,
	input logic arst_n,
	// Redirect pulse from the pipeline
	input logic redirect,
	input fetch_pkg::addr_t redirect_addr,
	// Request toward the memory access controller
	input logic fetch_lock,
	output logic fetch_req,
	output fetch_pkg::addr_t fetch_addr,
	// Path identifier, toggles on each redirect
	output logic cur_epoch
);

	// Set on the first edge after reset, then stays high
	logic run;
	// Address of the next fetch
	fetch_pkg::addr_t pc;
	// Request taken by the controller this cycle
	logic fetch_taken;
	// Redirect target rounded down to a fetch boundary
	fetch_pkg::addr_t redirect_aligned;

	assign redirect_aligned = redirect_addr & ~fetch_pkg::addr_t'(`FETCH_STEP - 1);

	// Nothing issued in the redirect cycle
	// The PC still points at the old path there
	assign fetch_req = run & ~redirect;
	assign fetch_addr = pc;
	assign fetch_taken = fetch_req & ~fetch_lock;

	always_ff @(posedge iclock or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
			pc <= `FETCH_RESET_VECTOR;
			cur_epoch <= 1'b0;
		end else begin
			run <= 1'b1;
			// Redirect wins over a normal advance
			if (redirect) begin
				pc <= redirect_aligned;
				// Replies from the old path become stale in the bridge
				cur_epoch <= ~cur_epoch;
			end else if (fetch_taken) begin
				pc <= pc + fetch_pkg::addr_t'(`FETCH_STEP);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/inst_fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module inst_fetch_unit (
	input logic iclock,
	input logic arst_n,
	// Branch redirect from the pipeline
	input logic redirect,
	input fetch_pkg::addr_t redirect_addr,
	// Instruction memory request
	output logic mem_req,
	output fetch_pkg::addr_t mem_addr,
	input logic mem_lock,
	// Instruction memory reply
	input logic mem_valid,
	input fetch_pkg::inst_data_t mem_data,
	output logic mem_busy,
	// Delivery to the pipeline
	output logic inst_valid,
	output fetch_pkg::addr_t inst_addr,
	output fetch_pkg::inst_data_t inst_data,
	input logic inst_busy
);

	// Sequencer to controller
	logic fetch_req;
	fetch_pkg::addr_t fetch_addr;
	logic fetch_lock;
	// Path tag for stale reply filtering
	logic cur_epoch;
	// Controller and bridge
	logic push;
	logic bridge_full;

	inst_fetch u_fetch (
		.iclock(iclock),
		.arst_n(arst_n),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.fetch_lock(fetch_lock),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.cur_epoch(cur_epoch)
	);

	inst_mem_access u_mem_access (
		.iclock(iclock),
		.arst_n(arst_n),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_lock(fetch_lock),
		.bridge_full(bridge_full),
		.push(push),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_lock(mem_lock)
	);

	// Pushed address is the one the controller latches
	inst_matching_bridge u_bridge (
		.iclock(iclock),
		.arst_n(arst_n),
		.push(push),
		.push_addr(fetch_addr),
		.push_epoch(cur_epoch),
		.cur_epoch(cur_epoch),
		.redirect(redirect),
		.bridge_full(bridge_full),
		.mem_valid(mem_valid),
		.mem_data(mem_data),
		.mem_busy(mem_busy),
		.inst_valid(inst_valid),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.inst_busy(inst_busy)
	);

endmodule

`default_nettype wire

//--- source/inst_matching_bridge.sv
`timescale 1ns/1ns
`default_nettype none
`include "fetch_defs.svh"

module inst_matching_bridge (
	input logic iclock,
	input logic arst_n,
	// Accepted fetch from the controller
	input logic push,
	input fetch_pkg::addr_t push_addr,
	input logic push_epoch,
	input logic cur_epoch,
	input logic redirect,
	output logic bridge_full,
	// Memory reply port
	input logic mem_valid,
	input fetch_pkg::inst_data_t mem_data,
	output logic mem_busy,
	// Delivery to the pipeline
	output logic inst_valid,
	output fetch_pkg::addr_t inst_addr,
	output fetch_pkg::inst_data_t inst_data,
	input logic inst_busy
);

	// Outstanding request storage
	fetch_pkg::addr_t addr_mem [`FETCH_BRIDGE_DEPTH];
	logic epoch_mem [`FETCH_BRIDGE_DEPTH];
	fetch_pkg::bridge_ptr_t wr_ptr;
	fetch_pkg::bridge_ptr_t rd_ptr;
	logic [fetch_pkg::BRIDGE_IDX_W-1:0] wr_idx;
	logic [fetch_pkg::BRIDGE_IDX_W-1:0] rd_idx;
	logic empty;
	logic head_stale;
	logic discard;
	logic deliver;
	logic pop;

	assign wr_idx = wr_ptr[fetch_pkg::BRIDGE_IDX_W-1:0];
	assign rd_idx = rd_ptr[fetch_pkg::BRIDGE_IDX_W-1:0];
	assign empty = (wr_ptr == rd_ptr);
	// Same index, different wrap bit
	assign bridge_full = (wr_ptr[fetch_pkg::BRIDGE_IDX_W] != rd_ptr[fetch_pkg::BRIDGE_IDX_W]) &&
		(wr_idx == rd_idx);

	// Head belongs to an old path, or a redirect kills it now
	assign head_stale = redirect | (epoch_mem[rd_idx] != cur_epoch);

	// Reply pairs with the head entry, in request order
	assign inst_valid = mem_valid & ~empty & ~head_stale;
	assign inst_addr = addr_mem[rd_idx];
	assign inst_data = mem_data;

	// Stale replies are dropped without waiting on the pipeline
	assign discard = mem_valid & ~empty & head_stale;
	assign mem_busy = inst_busy & ~discard;
	assign deliver = inst_valid & ~inst_busy;
	assign pop = deliver | discard;

	always_ff @(posedge iclock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge iclock) begin
		if (push) begin
			addr_mem[wr_idx] <= push_addr;
		end
	end

	// On redirect every entry takes the outgoing epoch
	// so it mismatches even after two quick redirects
	always_ff @(posedge iclock) begin
		if (redirect) begin
			for (int i = 0; i < `FETCH_BRIDGE_DEPTH; i++) begin
				epoch_mem[i] <= cur_epoch;
			end
		end
		if (push) begin
			epoch_mem[wr_idx] <= push_epoch;
		end
	end

endmodule

`default_nettype wire

//--- source/inst_mem_access.sv
`timescale 1ns/1ns
`default_nettype none

module inst_mem_access (
	input logic iclock,
	input logic arst_n,
	// From the PC sequencer
	input logic fetch_req,
	input fetch_pkg::addr_t fetch_addr,
	output logic fetch_lock,
	// Bridge side
	input logic bridge_full,
	output logic push,
	// Instruction memory request port
	output logic mem_req,
	output fetch_pkg::addr_t mem_addr,
	input logic mem_lock
);

	fetch_pkg::mem_state_t state;
	fetch_pkg::mem_state_t state_next;
	// Request buffer, held stable while the memory locks
	fetch_pkg::addr_t addr_q;
	// Memory takes the held request on this edge
	logic mem_taken;
	logic holding;

	assign holding = (state == fetch_pkg::MEM_HOLD);
	assign mem_taken = holding & ~mem_lock;

	// Blocked by a locked request or no room to track another reply
	assign fetch_lock = bridge_full | (holding & mem_lock);

	// Every accepted fetch gets a bridge entry
	assign push = fetch_req & ~fetch_lock;

	always_comb begin
		state_next = state;
		case (state)
			fetch_pkg::MEM_IDLE: begin
				if (push) begin
					state_next = fetch_pkg::MEM_HOLD;
				end
			end
			fetch_pkg::MEM_HOLD: begin
				// Back to back requests stay in HOLD
				if (mem_taken && !push) begin
					state_next = fetch_pkg::MEM_IDLE;
				end
			end
			default: state_next = fetch_pkg::MEM_IDLE;
		endcase
	end

	always_ff @(posedge iclock or negedge arst_n) begin
		if (!arst_n) begin
			state <= fetch_pkg::MEM_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Latch a new address only when a fetch is accepted
	always_ff @(posedge iclock) begin
		if (push) begin
			addr_q <= fetch_addr;
		end
	end

	assign mem_req = holding;
	assign mem_addr = addr_q;

endmodule

`default_nettype wire

//--- test/inst_fetch_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module inst_fetch_asserts (
	input logic iclock,
	input logic arst_n,
	input logic push,
	input logic bridge_full,
	input logic redirect,
	input logic mem_valid,
	input logic empty,
	input logic inst_valid,
	input fetch_pkg::addr_t inst_addr,
	input logic inst_busy
);

	// Count of failed checks
	int fail_count;

	// Controller must stop issuing while the FIFO is full
	no_push_when_full: assert property (@(posedge iclock) disable iff (!arst_n)
		bridge_full |-> !push)
		else begin
			fail_count++;
			$error("push into a full bridge");
		end

	// Held delivery stays put until taken, only a redirect may drop it
	delivery_stable: assert property (@(posedge iclock) disable iff (!arst_n)
		(inst_valid && inst_busy) |=> (redirect || (inst_valid && $stable(inst_addr))))
		else begin
			fail_count++;
			$error("delivery changed while inst_busy was high");
		end

	// Every memory reply has a recorded request
	no_underflow: assert property (@(posedge iclock) disable iff (!arst_n)
		mem_valid |-> !empty)
		else begin
			fail_count++;
			$error("memory reply while the bridge was empty");
		end

endmodule

bind inst_matching_bridge inst_fetch_asserts u_asserts (.*);

`default_nettype wire

//--- test/tb_inst_fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "fetch_defs.svh"

module tb_inst_fetch_unit;

	// 5 tests x 200 deliveries x 4 cycles worst case
	localparam int TIMEOUT_CYCLES = 5 * 200 * 4;

	logic iclock = 1'b0;
	logic arst_n = 1'b0;
	logic redirect;
	fetch_pkg::addr_t redirect_addr;
	logic mem_req;
	fetch_pkg::addr_t mem_addr;
	logic mem_lock;
	logic mem_valid;
	fetch_pkg::inst_data_t mem_data;
	logic mem_busy;
	logic inst_valid;
	fetch_pkg::addr_t inst_addr;
	fetch_pkg::inst_data_t inst_data;
	logic inst_busy;

	// Stimulus knobs, chances in percent, reply gap in cycles
	int lock_pct;
	int busy_pct;
	int redir_pct;
	int delay_lo;
	int delay_span;
	logic withhold;
	// Memory model state
	fetch_pkg::addr_t mem_q [$];
	int reply_wait;
	logic reply_taken;
	logic [31:0] rnd_state;
	fetch_pkg::addr_t exp_addr;
	int cycle;
	int deliveries;
	int errors;
	int tests;

	inst_fetch_unit UUT (.*);

	always #20 iclock = ~iclock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift(rnd_state);
		return rnd_state;
	endfunction

	function automatic logic chance(input int pct);
		return int'(next_rand() % 32'd100) < pct;
	endfunction

	// Scrambled address on top, plain address below
	function automatic fetch_pkg::inst_data_t ref_data(input fetch_pkg::addr_t a);
		return {xorshift(a ^ 32'h5a5a_0f0f), a};
	endfunction

	// Next expected address, a redirect restarts at the target rounded down
	function automatic fetch_pkg::addr_t ref_next_addr(input fetch_pkg::addr_t cur,
			input logic redir, input fetch_pkg::addr_t tgt);
		if (redir) begin
			return tgt - (tgt % fetch_pkg::addr_t'(`FETCH_STEP));
		end
		return cur + fetch_pkg::addr_t'(`FETCH_STEP);
	endfunction

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic run_test(input string name, input int count, input int lock_p,
			input int busy_p, input int redir_p, input int lo, input int span);
		int start_deliv;
		int start_err;
		lock_pct = lock_p;
		busy_pct = busy_p;
		redir_pct = redir_p;
		delay_lo = lo;
		delay_span = span;
		start_deliv = deliveries;
		start_err = errors;
		wait (deliveries >= start_deliv + count);
		tests++;
		$display("%s: %0d deliveries, %0d errors", name, count, errors - start_err);
	endtask

	// Handshakes resolve on the rising edge, compare deliveries here
	always @(posedge iclock) begin
		if (arst_n) begin
			cycle++;
			if (cycle >= TIMEOUT_CYCLES) begin
				$display("Timed out after %0d cycles, deliveries stopped", cycle);
				$display("Test failed");
				$finish;
			end else begin
				if (inst_valid && !inst_busy) begin
					check("delivered address", inst_addr, exp_addr);
					check("delivered data", inst_data, ref_data(exp_addr));
					exp_addr = ref_next_addr(exp_addr, 1'b0, '0);
					deliveries++;
				end
				if (mem_valid && !mem_busy) begin
					void'(mem_q.pop_front());
					reply_taken = 1'b1;
				end
				if (mem_req && !mem_lock) begin
					mem_q.push_back(mem_addr);
				end
				if (mem_q.size() > `FETCH_BRIDGE_DEPTH) begin
					errors++;
					$display("Memory holds %0d requests, more than the bridge tracks",
						mem_q.size());
				end
			end
		end
	end

	// Memory and pipeline models drive on the falling edge
	always @(negedge iclock) begin
		if (arst_n) begin
			mem_lock = chance(lock_pct);
			inst_busy = chance(busy_pct);
			redirect = !redirect && chance(redir_pct);
			redirect_addr = next_rand();
			if (redirect) begin
				exp_addr = ref_next_addr(exp_addr, 1'b1, redirect_addr);
			end
			// Reply held until the bridge takes it
			if (!mem_valid || reply_taken) begin
				mem_valid = 1'b0;
				if (reply_wait > 0) begin
					reply_wait--;
				end else if (mem_q.size() > 0 && !withhold) begin
					mem_valid = 1'b1;
					mem_data = ref_data(mem_q[0]);
					reply_wait = delay_lo + int'(next_rand() % 32'(delay_span));
				end
			end
			reply_taken = 1'b0;
		end
	end

	initial begin
		redirect = 1'b0;
		redirect_addr = '0;
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_data = '0;
		inst_busy = 1'b0;
		withhold = 1'b0;
		reply_wait = 0;
		reply_taken = 1'b0;
		rnd_state = 32'hbf39;
		exp_addr = `FETCH_RESET_VECTOR;
		repeat (5) begin
			@(posedge iclock);
			@(negedge iclock);
			check("mem_req in reset", mem_req, 0);
			check("inst_valid in reset", inst_valid, 0);
			check("mem_busy in reset", mem_busy, 0);
		end
		// Models start driving on the falling edge after release
		arst_n <= 1'b1;
		run_test("reset", 1, 0, 0, 0, 0, 1);
		run_test("sequential fetch", 100, 0, 0, 0, 0, 1);
		run_test("memory lock and latency", 150, 40, 0, 0, 0, 6);
		run_test("pipeline back-pressure", 150, 0, 50, 0, 0, 3);
		run_test("redirect", 100, 20, 20, 5, 3, 3);
		// Replies withheld, the bridge fills and stops the sequencer
		redir_pct = 0;
		withhold = 1'b1;
		repeat (20) @(negedge iclock);
		check("requests in flight", mem_q.size(), `FETCH_BRIDGE_DEPTH);
		@(posedge iclock);
		withhold = 1'b0;
		run_test("full bridge", 40, 0, 0, 0, 0, 2);
		errors += UUT.u_bridge.u_asserts.fail_count;
		$display("%0d tests, %0d deliveries, %0d errors", tests, deliveries, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
